/* logic/gpio_mux_pkg.sv */
////////////////////
// gpio mux shared constants
// pad count, select packing and wishbone sizes
////////////////////

`default_nettype none

package gpio_mux_pkg;

    // number of gpio pads on the chip
    localparam int NUM_PINS = 38;

    // width of one pad's source select
    // 4 bits give up to 15 teams plus the management source
    localparam int SEL_W = 4;

    // selects packed into one register word
    localparam int PINS_PER_WORD = 8;

    // register words holding the selects
    // last word only fills its low 24 bits
    localparam int NUM_SEL_WORDS = 5;

    // wishbone data width and word address width
    localparam int WB_DAT_W = 32;
    localparam int WB_ADR_W = 3;

    // select value of the management source
    localparam logic [SEL_W-1:0] MGMT_SRC = 4'd0;

endpackage

`default_nettype wire

/* logic/gpio_sel_regs.sv */
////////////////////
// gpio select registers
// wishbone slave holding one 4-bit source select per pad,
// eight selects per word, with read-back
////////////////////

`default_nettype none

module gpio_sel_regs #(
    parameter int NUM_TEAMS = 12
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    // wishbone slave port
    input  logic                                                 wb_cyc,
    input  logic                                                 wb_stb,
    input  logic                                                 wb_we,
    input  logic [gpio_mux_pkg::WB_ADR_W-1:0]                    wb_adr,
    input  logic [gpio_mux_pkg::WB_DAT_W-1:0]                    wb_dat_w,
    input  logic [gpio_mux_pkg::WB_DAT_W/8-1:0]                  wb_sel,
    output logic [gpio_mux_pkg::WB_DAT_W-1:0]                    wb_dat_r,
    output logic                                                 wb_ack,
    // pad p's select at bits 4p..4p+3
    output logic [gpio_mux_pkg::NUM_PINS*gpio_mux_pkg::SEL_W-1:0] sel_flat
);
    import gpio_mux_pkg::*;

    localparam int NUM_LANES = WB_DAT_W / 8;
    // pads living in the last, partly used word
    localparam int LAST_PINS = NUM_PINS - (NUM_SEL_WORDS - 1) * PINS_PER_WORD;
    localparam logic [WB_DAT_W-1:0] LAST_MASK = {WB_DAT_W{1'b1}} >> (WB_DAT_W - LAST_PINS * SEL_W);
    // every pad on the management source
    localparam logic [WB_DAT_W-1:0] RESET_WORD = {PINS_PER_WORD{MGMT_SRC}};

    // 4-bit selects cannot name more than 15 teams
    if (NUM_TEAMS < 1 || NUM_TEAMS > 2**SEL_W - 1) begin : g_bad_teams
        $error("gpio_sel_regs: NUM_TEAMS out of range 1..15");
    end

    logic [WB_DAT_W-1:0] sel_words [NUM_SEL_WORDS];
    logic                req;
    logic                addr_hit;
    logic [WB_DAT_W-1:0] cur_word;
    logic [WB_DAT_W-1:0] wr_word;

    // bits of word idx that hold real selects
    function automatic logic [WB_DAT_W-1:0] word_mask(input int idx);
        word_mask = (idx == NUM_SEL_WORDS - 1) ? LAST_MASK : {WB_DAT_W{1'b1}};
    endfunction

    // fresh request, the cycle being acked does not count twice
    assign req      = wb_cyc && wb_stb && !wb_ack;
    // addresses 5..7 are unmapped
    assign addr_hit = (int'(wb_adr) < NUM_SEL_WORDS);

    // addressed word, zero when unmapped
    always_comb begin
        cur_word = '0;
        if (addr_hit) begin
            cur_word = sel_words[wb_adr];
        end
    end

    // byte-lane merge of write data over the current word
    always_comb begin
        wr_word = cur_word;
        for (int b = 0; b < NUM_LANES; b++) begin
            if (wb_sel[b]) begin
                wr_word[b*8 +: 8] = wb_dat_w[b*8 +: 8];
            end
        end
    end

    // ack and read data, one cycle after the request
    // dat_r stays zero whenever ack is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack   <= req;
            wb_dat_r <= (req && !wb_we) ? cur_word : '0;
        end
    end

    // select words, written on the same edge that raises ack
    // unused top byte of the last word is forced to zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < NUM_SEL_WORDS; w++) begin
                sel_words[w] <= RESET_WORD & word_mask(w);
            end
        end else if (req && wb_we && addr_hit) begin
            for (int w = 0; w < NUM_SEL_WORDS; w++) begin
                if (w == int'(wb_adr)) begin
                    sel_words[w] <= wr_word & word_mask(w);
                end
            end
        end
    end

    // unpack words into one flat select vector for the mux
    always_comb begin
        for (int p = 0; p < NUM_PINS; p++) begin
            sel_flat[p*SEL_W +: SEL_W] =
                sel_words[p / PINS_PER_WORD][(p % PINS_PER_WORD) * SEL_W +: SEL_W];
        end
    end

    // single-beat bus, so ack is a one-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("gpio_sel_regs: ack high two cycles running");

    // no ack without a master request on the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("gpio_sel_regs: ack without a request");

endmodule

`default_nettype wire

/* logic/gpio_pin_mux.sv */
////////////////////
// gpio pin mux
// routes the selected team's out and oeb onto each pad,
// parks pads whose select names no team
////////////////////

`default_nettype none

module gpio_pin_mux #(
    parameter int NUM_TEAMS = 12
) (
    // flat select vector, pad p at bits 4p..4p+3
    input  logic [gpio_mux_pkg::NUM_PINS*gpio_mux_pkg::SEL_W-1:0] sel_flat,
    // index 0 is the management source, 1..NUM_TEAMS the teams
    input  logic [gpio_mux_pkg::NUM_PINS-1:0]                     io_out [NUM_TEAMS:0],
    input  logic [gpio_mux_pkg::NUM_PINS-1:0]                     io_oeb [NUM_TEAMS:0],
    // to the pads
    output logic [gpio_mux_pkg::NUM_PINS-1:0]                     muxed_io_out,
    output logic [gpio_mux_pkg::NUM_PINS-1:0]                     muxed_io_oeb
);
    import gpio_mux_pkg::*;

    // parked pad: driver off, output low
    localparam logic PARK_OUT = 1'b0;
    localparam logic PARK_OEB = 1'b1;

    // per-pad selection
    always_comb begin
        logic [SEL_W-1:0] sel;

        sel = '0;
        for (int p = 0; p < NUM_PINS; p++) begin
            sel = sel_flat[p*SEL_W +: SEL_W];
            if (int'(sel) <= NUM_TEAMS) begin
                // pad p only ever takes bit p of its source
                muxed_io_out[p] = io_out[sel][p];
                muxed_io_oeb[p] = io_oeb[sel][p];
            end else begin
                // select above NUM_TEAMS, no such team
                muxed_io_out[p] = PARK_OUT;
                muxed_io_oeb[p] = PARK_OEB;
            end
        end
    end

    // once selects and team arrays are known the pads must be too
    // catches an unused team index leaking X onto a pad
    always_comb begin
        logic known;

        known = !$isunknown(sel_flat);
        for (int t = 0; t <= NUM_TEAMS; t++) begin
            if ($isunknown(io_out[t]) || $isunknown(io_oeb[t])) begin
                known = 1'b0;
            end
        end
        if (known) begin
            pads_known: assert final (!$isunknown({muxed_io_out, muxed_io_oeb}))
                else $error("gpio_pin_mux: X or Z on a pad output");
        end
    end

endmodule

`default_nettype wire

/* logic/gpio_mux_top.sv */
////////////////////
// gpio mux top
// select registers on wishbone feeding the pad mux
////////////////////

`default_nettype none

module gpio_mux_top #(
    // number of design teams, 1..15
    parameter int NUM_TEAMS = 12
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // wishbone slave port
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [gpio_mux_pkg::WB_ADR_W-1:0]   wb_adr,
    input  logic [gpio_mux_pkg::WB_DAT_W-1:0]   wb_dat_w,
    input  logic [gpio_mux_pkg::WB_DAT_W/8-1:0] wb_sel,
    output logic [gpio_mux_pkg::WB_DAT_W-1:0]   wb_dat_r,
    output logic                                wb_ack,
    // team sources, index 0 is management
    input  logic [gpio_mux_pkg::NUM_PINS-1:0]   io_out [NUM_TEAMS:0],
    input  logic [gpio_mux_pkg::NUM_PINS-1:0]   io_oeb [NUM_TEAMS:0],
    // pad side
    output logic [gpio_mux_pkg::NUM_PINS-1:0]   muxed_io_out,
    output logic [gpio_mux_pkg::NUM_PINS-1:0]   muxed_io_oeb
);
    import gpio_mux_pkg::*;

    // selects from the registers, level signals into the mux
    logic [NUM_PINS*SEL_W-1:0] sel_flat;

    gpio_sel_regs #(
        .NUM_TEAMS (NUM_TEAMS)
    ) i_sel_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sel_flat (sel_flat)
    );

    // combinational, a select write shows on the pads right after its ack edge
    gpio_pin_mux #(
        .NUM_TEAMS (NUM_TEAMS)
    ) i_pin_mux (
        .sel_flat     (sel_flat),
        .io_out       (io_out),
        .io_oeb       (io_oeb),
        .muxed_io_out (muxed_io_out),
        .muxed_io_oeb (muxed_io_oeb)
    );

endmodule

`default_nettype wire

/* verif/gpio_mux_tb.sv */
////////////////////
// gpio mux testbench
// plays golden wishbone vectors, checks read-back,
// ack timing and per-pad routing against a reference model
////////////////////

`default_nettype none

module gpio_mux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import gpio_mux_pkg::*;

    localparam int    NUM_TEAMS   = 12;
    localparam int    CLK_PERIOD  = 20;
    localparam int    RST_CYCLES  = 4;
    localparam string GOLDEN_FILE = "verif/gpio_mux_golden.txt";

    logic                  clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_ADR_W-1:0]   wb_adr;
    logic [WB_DAT_W-1:0]   wb_dat_w;
    logic [WB_DAT_W/8-1:0] wb_sel;
    logic [WB_DAT_W-1:0]   wb_dat_r;
    logic                  wb_ack;
    logic [NUM_PINS-1:0]   io_out [NUM_TEAMS:0];
    logic [NUM_PINS-1:0]   io_oeb [NUM_TEAMS:0];
    logic [NUM_PINS-1:0]   muxed_io_out;
    logic [NUM_PINS-1:0]   muxed_io_oeb;

    // expected select words, kept from the golden writes
    logic [WB_DAT_W-1:0] shadow [NUM_SEL_WORDS];
    logic [31:0]         lfsr_state;
    string               lines [$];
    int                  num_lines;
    bit                  loaded;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    gpio_mux_top #(
        .NUM_TEAMS (NUM_TEAMS)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .io_out       (io_out),
        .io_oeb       (io_oeb),
        .muxed_io_out (muxed_io_out),
        .muxed_io_oeb (muxed_io_oeb)
    );

    task automatic fail_value(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // select of pad p as the shadow words hold it
    function automatic logic [SEL_W-1:0] pad_select(input int p);
        return shadow[p / PINS_PER_WORD][(p % PINS_PER_WORD) * SEL_W +: SEL_W];
    endfunction

    // expected read data, unmapped addresses read zero
    function automatic logic [WB_DAT_W-1:0] shadow_read(input int adr);
        if (adr < NUM_SEL_WORDS) begin
            return shadow[adr];
        end
        return '0;
    endfunction

    // byte-lane merge, word 4 keeps only 24 bits, 5..7 store nothing
    task automatic shadow_write(input int adr, input logic [3:0] be, input logic [31:0] dat);
        if (adr < NUM_SEL_WORDS) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[adr][b*8 +: 8] = dat[b*8 +: 8];
                end
            end
            if (adr == NUM_SEL_WORDS - 1) begin
                shadow[adr][31:24] = 8'h00;
            end
        end
    endtask

    // one lfsr step per bit, out and oeb interleaved
    task automatic fill_teams();
        for (int t = 0; t <= NUM_TEAMS; t++) begin
            for (int p = 0; p < NUM_PINS; p++) begin
                lfsr_state = lfsr_step(lfsr_state);
                io_out[t][p] = lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
                io_oeb[t][p] = lfsr_state[0];
            end
        end
    endtask

    // reference mux, team bits for selects up to NUM_TEAMS, parked above
    task automatic compare_pads();
        logic [SEL_W-1:0] s;
        logic             exp_out;
        logic             exp_oeb;
        for (int p = 0; p < NUM_PINS; p++) begin
            s = pad_select(p);
            if (int'(s) <= NUM_TEAMS) begin
                exp_out = io_out[s][p];
                exp_oeb = io_oeb[s][p];
            end else begin
                exp_out = 1'b0;
                exp_oeb = 1'b1;
            end
            assert (muxed_io_out[p] === exp_out && muxed_io_oeb[p] === exp_oeb)
                else fail_value($sformatf("pad %0d select %0d: out %b oeb %b, expected %b %b",
                    p, s, muxed_io_out[p], muxed_io_oeb[p], exp_out, exp_oeb));
        end
    endtask

    // new pattern on a falling edge, pads sampled one falling edge later
    task automatic check_pads(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            fill_teams();
            @(negedge clk);
            compare_pads();
        end
    endtask

    // single-beat cycle, ack must come exactly one cycle after the request
    task automatic bus_cycle(input logic we, input int adr, input logic [3:0] be,
                             input logic [31:0] dat, output logic [31:0] rdata);
        @(negedge clk);
        assert (wb_ack === 1'b0)
            else fail_value("ack high while the bus is idle");
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[WB_ADR_W-1:0];
        wb_dat_w = dat;
        wb_sel   = be;
        @(negedge clk);
        assert (wb_ack === 1'b1)
            else fail_value($sformatf("no ack one cycle after request to address %0d", adr));
        rdata    = wb_dat_r;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        @(negedge clk);
        assert (wb_ack === 1'b0)
            else fail_value("ack held for more than one cycle");
        assert (wb_dat_r === '0)
            else fail_value($sformatf("read data %h while idle, expected zero", wb_dat_r));
    endtask

    task automatic load_golden();
        int    fd;
        string line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open the golden file ", GOLDEN_FILE});
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        num_lines = lines.size();
        loaded    = 1'b1;
    endtask

    // one golden line, comments and blank lines skipped
    task automatic run_line(input string line, inout bit done);
        byte         cmd;
        string       args;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] rdata;
        if (line.len() == 0) begin
            return;
        end
        cmd  = line.getc(0);
        args = line.substr(1, line.len() - 1);
        case (cmd)
            "#", "\n", "\r", " ": begin
            end
            "W": begin
                n = $sscanf(args, "%h %h %h", a, b, d);
                if (n != 3) begin
                    abort_run({"malformed write line in golden file: ", line});
                end
                bus_cycle(1'b1, int'(a), b[3:0], d, rdata);
                // write acks carry no data
                assert (rdata === '0)
                    else fail_value($sformatf("read data %h during write ack", rdata));
                shadow_write(int'(a), b[3:0], d);
            end
            "R": begin
                n = $sscanf(args, "%h %h", a, d);
                if (n != 2) begin
                    abort_run({"malformed read line in golden file: ", line});
                end
                bus_cycle(1'b0, int'(a), 4'hf, '0, rdata);
                assert (d === shadow_read(int'(a)))
                    else fail_value($sformatf("golden expects %h at address %0d, model holds %h",
                        d, a, shadow_read(int'(a))));
                assert (rdata === d)
                    else fail_value($sformatf("read address %0d returned %h, expected %h",
                        a, rdata, d));
            end
            "C": begin
                n = $sscanf(args, "%h", a);
                if (n != 1) begin
                    abort_run({"malformed check line in golden file: ", line});
                end
                check_pads(int'(a));
            end
            "E": begin
                done = 1'b1;
            end
            default: begin
                abort_run($sformatf("unknown golden command '%c'", cmd));
            end
        endcase
    endtask

    initial begin : main
        bit done;
        int idx;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        lfsr_state = 32'hb94d;
        for (int t = 0; t <= NUM_TEAMS; t++) begin
            io_out[t] = '0;
            io_oeb[t] = '0;
        end
        // management source is select 0 on every pad
        for (int w = 0; w < NUM_SEL_WORDS; w++) begin
            shadow[w] = '0;
        end
        load_golden();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        done  = 1'b0;
        idx   = 0;
        while (!done && idx < lines.size()) begin
            run_line(lines[idx], done);
            idx++;
        end
        if (done) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("golden file ended without an end command");
        end
    end

    // 40 cycles per golden line plus 200 of slack
    initial begin : watchdog
        wait (loaded);
        #((num_lines * 40 + 200) * CLK_PERIOD);
        $display("run hung, no end of test within %0d cycles", num_lines * 40 + 200);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* src.f */
logic/gpio_mux_pkg.sv
logic/gpio_sel_regs.sv
logic/gpio_pin_mux.sv
logic/gpio_mux_top.sv
verif/gpio_mux_tb.sv

/* Makefile */
# Verilator build and run of the gpio mux testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= gpio_mux_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/gpio_mux_golden.txt */
# all fields hex: W adr be data = bus write | R adr data = read, expect data
# C n = n random team patterns checked on every pad | E = end of vectors
# after reset every word selects the management source
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
C 8
# full-word writes, team selects 0..12 on every pad
W 0 f 76543210
R 0 76543210
W 1 f 0cba9876
R 1 0cba9876
W 2 f 5a6b7c01
R 2 5a6b7c01
W 3 f 2468ac13
R 3 2468ac13
# top byte of word 4 is not stored
W 4 f 5ac3b2c1
R 4 00c3b2c1
C 12
# byte-lane writes merge into the old word
W 0 1 000000ab
R 0 765432ab
W 0 4 00c90000
R 0 76c932ab
W 1 a 11223344
R 1 11ba3376
W 3 6 00ffee00
R 3 24ffee13
W 4 8 99000000
R 4 00c3b2c1
W 4 3 0000a7b8
R 4 00c3a7b8
W 2 c 12340000
R 2 12347c01
W 2 0 ffffffff
R 2 12347c01
C 12
# selects 13..15 park their pads
W 0 f fedcfedc
R 0 fedcfedc
W 1 f dddddddd
R 1 dddddddd
W 4 f ffffffff
R 4 00ffffff
C 10
# addresses 5..7 ack, read zero, store nothing
W 5 f 12345678
R 5 00000000
W 6 f 9abcdef0
R 6 00000000
W 7 f 0f0f0f0f
R 7 00000000
R 0 fedcfedc
R 1 dddddddd
R 2 12347c01
R 3 24ffee13
R 4 00ffffff
C 6
# parked and team selects mixed
W 3 f 0e1d2c3b
R 3 0e1d2c3b
W 1 5 00f000c0
R 1 ddf0ddc0
C 10
# back to the management source
W 0 f 00000000
W 1 f 00000000
W 2 f 00000000
W 3 f 00000000
W 4 f 00000000
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
C 8
E
